// File: hw/sap_isa_pkg.sv
`default_nettype none

package sap_isa_pkg;

    localparam int OPCODE_W = 4;

    // Upper nibble of an instruction
    typedef enum logic [OPCODE_W-1:0] {
        HLT = 4'h0,
        NOP = 4'h1,
        ADD = 4'h2,
        SUB = 4'h3,
        LDA = 4'h4,
        OUT = 4'h5,
        STA = 4'h6,
        JMP = 4'h7
    } opcode_t;

    // Word width follows from opcode plus address field
    function automatic int data_width(input int addr_width);
        return OPCODE_W + addr_width;
    endfunction

endpackage

`default_nettype wire

// File: hw/sap_ctrl_pkg.sv
`default_nettype none

package sap_ctrl_pkg;

    // Six micro-operation stages plus two holding stages
    typedef enum logic [2:0] {
        T0         = 3'd0,
        T1         = 3'd1,
        T2         = 3'd2,
        T3         = 3'd3,
        T4         = 3'd4,
        T5         = 3'd5,
        STAGE_IDLE = 3'd6,
        STAGE_HALT = 3'd7
    } stage_t;

    typedef struct packed {
        logic pc_inc;         // Advance PC
        logic pc_drive;       // PC onto bus
        logic pc_load;        // Jump target from bus
        logic mar_addr_load;  // MAR address from bus
        logic mar_data_load;  // MAR data from bus or host
        logic ram_drive;      // RAM word onto bus
        logic ram_write;      // MAR data into RAM
        logic ir_load;
        logic ir_drive;       // IR address field onto bus
        logic a_load;
        logic a_drive;
        logic alu_sub;        // Subtract instead of add
        logic alu_drive;
        logic b_load;
        logic out_load;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

`default_nettype wire

// File: hw/ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrl_if
    import sap_isa_pkg::*, sap_ctrl_pkg::*;
();

    ctrl_word_t word;    // Control word for the current stage
    logic       prog;    // Round belongs to programming mode
    opcode_t    opcode;  // Opcode field of the IR

    modport ctrl (
        output word,
        output prog,
        input  opcode
    );

    modport unit (
        input  word,
        input  prog,
        output opcode
    );

endinterface

`default_nettype wire

// File: hw/stage_counter.sv
`timescale 1ns/10ps
`default_nettype none

module stage_counter
    import sap_ctrl_pkg::*;
(
    input  wire logic clk,
    input  wire logic resetn,
    input  wire logic halt,
    output stage_t    stage
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage <= STAGE_IDLE;  // Holding stage for one cycle
        end else if (halt) begin
            stage <= STAGE_HALT;  // Frozen until reset
        end else begin
            case (stage)
                STAGE_IDLE: stage <= T0;
                T0:         stage <= T1;
                T1:         stage <= T2;
                T2:         stage <= T3;
                T3:         stage <= T4;
                T4:         stage <= T5;
                T5:         stage <= T0;
                STAGE_HALT: stage <= STAGE_HALT;
                default:    stage <= STAGE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/control_block.sv
`timescale 1ns/10ps
`default_nettype none

module control_block
    import sap_isa_pkg::*, sap_ctrl_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetn,
    input  wire stage_t stage,
    input  wire logic   prog_mode,
    ctrl_if.ctrl        bus,
    output logic        halt,
    output logic        prog_read,
    output logic        load_done,
    output logic        fetch_ready
);

    ctrl_word_t word;
    logic       mode;  // prog_mode as captured at the start of a run

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mode <= 1'b0;
            halt <= 1'b0;
        end else begin
            if (stage == STAGE_IDLE) begin
                mode <= prog_mode;
            end
            if (stage == T3 && !mode && bus.opcode == HLT) begin
                halt <= 1'b1;
            end
        end
    end

    always_comb begin
        word = CTRL_IDLE;
        case (stage)
            T0: begin
                word.pc_drive      = 1'b1;
                word.mar_addr_load = 1'b1;
            end
            T1: word.pc_inc = 1'b1;
            T2: begin
                word.ram_drive = !mode;
                word.ir_load   = !mode;
            end
            T3: begin
                if (mode) begin
                    word.mar_data_load = 1'b1;  // Host byte into MAR
                end else begin
                    case (bus.opcode)
                        ADD, SUB, LDA, STA: begin
                            word.ir_drive      = 1'b1;
                            word.mar_addr_load = 1'b1;
                        end
                        OUT: begin
                            word.a_drive  = 1'b1;
                            word.out_load = 1'b1;
                        end
                        JMP: begin
                            word.ir_drive = 1'b1;
                            word.pc_load  = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            T4: begin
                if (mode) begin
                    word.ram_write = 1'b1;
                end else begin
                    case (bus.opcode)
                        ADD, SUB: begin
                            word.ram_drive = 1'b1;
                            word.b_load    = 1'b1;
                        end
                        LDA: begin
                            word.ram_drive = 1'b1;
                            word.a_load    = 1'b1;
                        end
                        STA: begin
                            word.a_drive       = 1'b1;
                            word.mar_data_load = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            T5: begin
                if (!mode && (bus.opcode == ADD || bus.opcode == SUB)) begin
                    word.alu_sub   = (bus.opcode == SUB);
                    word.alu_drive = 1'b1;
                    word.a_load    = 1'b1;
                end
                if (!mode && bus.opcode == STA) begin
                    word.ram_write = 1'b1;
                end
            end
            default: ;  // Idle and halt stages drive nothing
        endcase
    end

    assign bus.word    = word;
    assign bus.prog    = mode;
    assign prog_read   = mode && stage == T3;  // Host byte expected now
    assign load_done   = mode && stage == T4;
    assign fetch_ready = stage == T0;

endmodule

`default_nettype wire

// File: hw/program_counter.sv
`timescale 1ns/10ps
`default_nettype none

module program_counter
    import sap_isa_pkg::*;
#(
    parameter int ADDR_WIDTH = 4,
    localparam int DATA_W = data_width(ADDR_WIDTH)
) (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire logic [DATA_W-1:0] bus_in,
    output logic [ADDR_WIDTH-1:0]  pc_value,
    ctrl_if.unit                   bus
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_value <= '0;
        end else if (bus.word.pc_load) begin
            pc_value <= bus_in[ADDR_WIDTH-1:0];  // Jump target from IR field
        end else if (bus.word.pc_inc) begin
            pc_value <= pc_value + 1'b1;  // Wraps at end of RAM
        end
    end

endmodule

`default_nettype wire

// File: hw/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath
    import sap_isa_pkg::*;
#(
    parameter int ADDR_WIDTH = 4,
    localparam int DATA_W = data_width(ADDR_WIDTH)
) (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire logic [DATA_W-1:0] bus_in,
    output logic [DATA_W-1:0]      bus_out,
    input  wire logic [DATA_W-1:0] prog_data,
    output logic [DATA_W-1:0]      out_data,
    output logic                   out_strobe,
    ctrl_if.unit                   bus
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [ADDR_WIDTH-1:0] mar_addr;
    logic [DATA_W-1:0]     mar_data;  // Write data staged for RAM
    logic [DATA_W-1:0]     ram [DEPTH];
    logic [DATA_W-1:0]     ir;
    logic [DATA_W-1:0]     reg_a;
    logic [DATA_W-1:0]     reg_b;
    logic [DATA_W-1:0]     alu_out;

    always_ff @(posedge clk) begin
        if (bus.word.mar_addr_load) begin
            mar_addr <= bus_in[ADDR_WIDTH-1:0];
        end
        if (bus.word.mar_data_load) begin
            mar_data <= bus.prog ? prog_data : bus_in;  // Host byte or A
        end
        if (bus.word.ram_write) begin
            ram[mar_addr] <= mar_data;
        end
        if (bus.word.ir_load) begin
            ir <= bus_in;
        end
        if (bus.word.a_load) begin
            reg_a <= bus_in;
        end
        if (bus.word.b_load) begin
            reg_b <= bus_in;
        end
        if (bus.word.out_load) begin
            out_data <= bus_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= bus.word.out_load;  // One cycle per OUT
        end
    end

    // Modulo 2^DATA_W, wraps below zero
    assign alu_out = bus.word.alu_sub ? reg_a - reg_b : reg_a + reg_b;

    always_comb begin
        if (bus.word.ram_drive) begin
            bus_out = ram[mar_addr];
        end else if (bus.word.ir_drive) begin
            bus_out = DATA_W'(ir[ADDR_WIDTH-1:0]);  // Address field only
        end else if (bus.word.a_drive) begin
            bus_out = reg_a;
        end else if (bus.word.alu_drive) begin
            bus_out = alu_out;
        end else begin
            bus_out = '0;
        end
    end

    assign bus.opcode = opcode_t'(ir[DATA_W-1 -: OPCODE_W]);

endmodule

`default_nettype wire

// File: hw/sap_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module sap_cpu
    import sap_isa_pkg::*, sap_ctrl_pkg::*;
#(
    parameter int ADDR_WIDTH = 4,
    localparam int DATA_W = data_width(ADDR_WIDTH)
) (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire logic              prog_mode,
    input  wire logic [DATA_W-1:0] prog_data,
    output logic [DATA_W-1:0]      out_data,
    output logic                   out_strobe,
    output logic                   prog_read,
    output logic                   load_done,
    output logic                   fetch_ready,
    output logic                   halted
);

    stage_t                stage;
    logic [ADDR_WIDTH-1:0] pc_value;
    logic [DATA_W-1:0]     dp_bus;
    logic [DATA_W-1:0]     data_bus;

    ctrl_if ctrl ();

    stage_counter u_stage (
        .clk    (clk),
        .resetn (resetn),
        .halt   (halted),
        .stage  (stage)
    );

    control_block u_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .stage       (stage),
        .prog_mode   (prog_mode),
        .bus         (ctrl.ctrl),
        .halt        (halted),
        .prog_read   (prog_read),
        .load_done   (load_done),
        .fetch_ready (fetch_ready)
    );

    program_counter #(.ADDR_WIDTH(ADDR_WIDTH)) u_pc (
        .clk      (clk),
        .resetn   (resetn),
        .bus_in   (data_bus),
        .pc_value (pc_value),
        .bus      (ctrl.unit)
    );

    datapath #(.ADDR_WIDTH(ADDR_WIDTH)) u_dp (
        .clk        (clk),
        .resetn     (resetn),
        .bus_in     (data_bus),
        .bus_out    (dp_bus),
        .prog_data  (prog_data),
        .out_data   (out_data),
        .out_strobe (out_strobe),
        .bus        (ctrl.unit)
    );

    // PC owns the bus only in T0
    assign data_bus = ctrl.word.pc_drive ? DATA_W'(pc_value) : dp_bus;

endmodule

`default_nettype wire

// File: test/sap_cpu_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module sap_cpu_asserts
    import sap_ctrl_pkg::*;
(
    input wire logic       clk,
    input wire logic       resetn,
    input wire logic       prog_mode,
    input wire logic       halt,
    input wire logic       prog_read,
    input wire stage_t     stage,
    input wire ctrl_word_t word
);

    logic [4:0] drivers;

    assign drivers = {word.pc_drive, word.ram_drive, word.ir_drive, word.a_drive, word.alu_drive};

    single_bus_driver: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(drivers))
        else $error("More than one source drives the bus");

    idle_after_halt: assert property (@(posedge clk) disable iff (!resetn)
        halt |-> word == CTRL_IDLE)
        else $error("Control word active while halted");

    // Halt holds and the stage freezes one cycle later
    halt_is_sticky: assert property (@(posedge clk) disable iff (!resetn)
        halt |=> halt && stage == STAGE_HALT)
        else $error("Processor left the halt stage without reset");

    prog_read_in_prog_mode: assert property (@(posedge clk) disable iff (!resetn)
        prog_read |-> prog_mode)
        else $error("prog_read raised outside programming mode");

endmodule

bind control_block sap_cpu_asserts u_asserts (
    .clk       (clk),
    .resetn    (resetn),
    .prog_mode (prog_mode),
    .halt      (halt),
    .prog_read (prog_read),
    .stage     (stage),
    .word      (word)
);

`default_nettype wire

// File: test/sap_cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sap_cpu_tb;

    localparam int ADDR_WIDTH  = 4;
    localparam int MAX_RECORDS = 8;
    localparam int MAX_OUTS    = 8;
    localparam int PROG_BYTES  = 16;
    localparam int TAIL_CYCLES = 12;  // Two rounds watched after halt

    logic       clk = 1'b0;
    logic       resetn;
    logic       prog_mode;
    logic [7:0] prog_data;
    logic [7:0] out_data;
    logic       out_strobe;
    logic       prog_read;
    logic       load_done;
    logic       fetch_ready;
    logic       halted;

    string      names    [MAX_RECORDS];
    logic [7:0] programs [MAX_RECORDS][PROG_BYTES];
    logic [7:0] exp_vals [MAX_RECORDS][MAX_OUTS];
    int         counts   [MAX_RECORDS];
    int         num_records = 0;
    logic       loaded = 1'b0;

    sap_cpu #(.ADDR_WIDTH(ADDR_WIDTH)) DUT (
        .clk         (clk),
        .resetn      (resetn),
        .prog_mode   (prog_mode),
        .prog_data   (prog_data),
        .out_data    (out_data),
        .out_strobe  (out_strobe),
        .prog_read   (prog_read),
        .load_done   (load_done),
        .fetch_ready (fetch_ready),
        .halted      (halted)
    );

    always #50 clk = ~clk;  // 100 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Packed token to string, leading null bytes dropped
    function automatic string name_text(input logic [255:0] raw);
        string s;
        s = "";
        for (int i = 31; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, raw[i*8 +: 8]);
            end
        end
        return s;
    endfunction

    task automatic read_test_data();
        int                 fd;
        int                 code;
        int                 count;
        logic [7:0]         value;
        logic [255:0]       token;
        logic [8*160-1:0]   rest;
        fd = $fopen("test/sap_cpu_testdata.txt", "r");
        assert (fd != 0) else abort_run("Cannot open test/sap_cpu_testdata.txt");
        forever begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) break;  // End of file
            if (token == "#") begin
                code = $fgets(rest, fd);  // Rest of a comment line
                continue;
            end
            assert (num_records < MAX_RECORDS) else abort_run("Too many records in the data file");
            names[num_records] = name_text(token);
            for (int i = 0; i < PROG_BYTES; i++) begin
                code = $fscanf(fd, "%h", value);
                assert (code == 1) else abort_run("Program bytes missing in the data file");
                programs[num_records][i] = value;
            end
            code = $fscanf(fd, "%d", count);
            assert (code == 1 && count >= 0 && count <= MAX_OUTS)
                else abort_run("Bad output count in the data file");
            counts[num_records] = count;
            for (int i = 0; i < count; i++) begin
                code = $fscanf(fd, "%h", value);
                assert (code == 1) else abort_run("Expected outputs missing in the data file");
                exp_vals[num_records][i] = value;
            end
            num_records++;
        end
        $fclose(fd);
    endtask

    task automatic apply_reset(input logic mode);
        @(negedge clk);
        resetn    = 1'b0;
        prog_mode = mode;  // Mode only changes inside reset
        repeat (5) @(negedge clk);
        resetn = 1'b1;
    endtask

    // One byte per prog_read, until sixteen writes are done
    task automatic load_program(input int r);
        int reads;
        int dones;
        reads = 0;
        dones = 0;
        apply_reset(1'b1);
        while (dones < PROG_BYTES) begin
            @(negedge clk);
            if (prog_read) begin
                assert (reads < PROG_BYTES) else abort_run("prog_read pulsed too often");
                prog_data = programs[r][reads];  // Captured at the end of T3
                reads++;
            end
            if (load_done) begin
                dones++;
            end
        end
        assert (reads == PROG_BYTES) else abort_run($sformatf(
            "MISMATCH %s prog_read count expected %0d actual %0d", names[r], PROG_BYTES, reads));
    endtask

    task automatic run_program(input int r);
        int   n;
        int   since_fetch;
        int   exp_gap;
        logic prev_strobe;
        n = 0;
        since_fetch = 0;
        exp_gap = 1;  // One idle cycle after reset
        prev_strobe = 1'b0;
        apply_reset(1'b0);
        while (!halted) begin
            @(negedge clk);
            since_fetch++;
            if (fetch_ready) begin
                assert (since_fetch == exp_gap) else abort_run($sformatf(
                    "MISMATCH %s fetch_ready spacing expected %0d actual %0d",
                    names[r], exp_gap, since_fetch));
                since_fetch = 0;
                exp_gap = 6;  // One instruction per six cycles
            end else begin
                assert (since_fetch < exp_gap)
                    else abort_run($sformatf("fetch_ready did not rise in %s", names[r]));
            end
            assert (!prog_read && !load_done)
                else abort_run($sformatf("Programming strobe raised while running %s", names[r]));
            if (out_strobe) begin
                assert (!prev_strobe) else abort_run("out_strobe stayed high for two cycles");
                assert (n < counts[r]) else abort_run($sformatf(
                    "MISMATCH %s output count expected %0d actual %0d", names[r], counts[r], n + 1));
                assert (out_data == exp_vals[r][n]) else abort_run($sformatf(
                    "MISMATCH %s output %0d expected %02h actual %02h",
                    names[r], n, exp_vals[r][n], out_data));
                n++;
            end
            prev_strobe = out_strobe;
        end
        assert (n == counts[r]) else abort_run($sformatf(
            "MISMATCH %s output count expected %0d actual %0d", names[r], counts[r], n));
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            assert (halted && !out_strobe && !fetch_ready) else abort_run($sformatf(
                "Processor left halt, fetched or produced output in %s", names[r]));
        end
    endtask

    initial begin : main
        resetn    = 1'b0;
        prog_mode = 1'b0;
        prog_data = 8'h00;
        read_test_data();
        assert (num_records > 0) else abort_run("The data file holds no test records");
        loaded = 1'b1;
        for (int r = 0; r < num_records; r++) begin
            load_program(r);
            run_program(r);
            $display("Test %s finished", names[r]);
        end
        $display("Done: no errors");
        $finish;
    end

    // Sixteen programming rounds plus forty run rounds per record
    initial begin : watchdog
        wait (loaded);
        repeat (num_records * 6 * (16 + 40)) @(posedge clk);
        abort_run("Timeout: the processor did not halt within the watchdog window");
    end

endmodule

`default_nettype wire

// File: test/sap_cpu_testdata.txt
# name  program bytes for addresses 0 to F (hex)  output count  expected outputs (hex)
# opcodes 0 HLT 1 NOP 2 ADD 3 SUB 4 LDA 5 OUT 6 STA 7 JMP
lda_out      4E 50 4F 50 4D 50 00 00 00 00 00 00 00 3C A5 5A  3  A5 5A 3C
add_sub_wrap 4D 2E 50 3F 50 2F 50 00 00 00 00 00 00 05 FE 07  3  03 FC 03
sta_lda      4E 2F 6C 4F 50 4C 50 00 00 00 00 00 00 00 81 11  2  11 92
jmp_skip     4F 50 76 4E 50 00 2E 50 7B 50 00 10 50 00 01 42  3  42 43 43
halt_only    00 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50  0

// File: sources.f
hw/sap_isa_pkg.sv
hw/sap_ctrl_pkg.sv
hw/ctrl_if.sv
hw/stage_counter.sv
hw/control_block.sv
hw/program_counter.sv
hw/datapath.sv
hw/sap_cpu.sv
test/sap_cpu_asserts.sv
test/sap_cpu_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the sap_cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module sap_cpu_tb -f sources.f -o sap_cpu_sim

status=0
./obj_dir/sap_cpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
